// File: vec_cfg_pkg.sv
/*
 * Shared types and constants for the vector configuration unit.
 * Imported by every RTL module that carries instructions, requests or results.
 */
package vec_cfg_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	typedef logic [31:0] elen_t;     // Scalar operand / result
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [1:0]  vxrm_t;     // Fixed-point rounding mode

	// {vill, vma, vta, vsew[2:0], vlmul[2:0]}
	typedef logic [8:0] vtype_t;

	localparam int unsigned VTYPE_VILL = 8;
	localparam vtype_t VTYPE_RESET = 9'h100; // Only vill set

	////////////////////////////////////////////////////////////
	// Opcodes and CSR addresses
	////////////////////////////////////////////////////////////

	localparam logic [6:0] OPCODE_VEC    = 7'h57;
	localparam logic [6:0] OPCODE_SYSTEM = 7'h73;
	localparam logic [2:0] FUNCT3_OPCFG  = 3'b111;

	localparam csr_addr_t CSR_VSTART = 12'h008;
	localparam csr_addr_t CSR_VXSAT  = 12'h009;
	localparam csr_addr_t CSR_VXRM   = 12'h00A;
	localparam csr_addr_t CSR_VCSR   = 12'h00F;
	localparam csr_addr_t CSR_VL     = 12'hC20;
	localparam csr_addr_t CSR_VTYPE  = 12'hC21;
	localparam csr_addr_t CSR_VLENB  = 12'hC22;

	////////////////////////////////////////////////////////////
	// Request and result
	////////////////////////////////////////////////////////////

	typedef enum logic {
		VCFG, // vsetvli, vsetivli, vsetvl
		VCSR  // Zicsr access to a vector CSR
	} vec_op_e;

	typedef enum logic [1:0] {
		CSR_WRITE,
		CSR_SET,
		CSR_CLEAR
	} csr_op_e;

	typedef struct packed {
		vec_op_e   op;
		csr_op_e   csr_op;
		csr_addr_t csr_addr;
		logic      csr_we;       // CSR actually written
		reg_idx_t  rd;
		logic      use_rd;
		elen_t     operand;      // AVL or CSR source value
		vtype_t    vtype;        // vill bit flags nonzero upper bits
		logic      keep_vl;
		logic      avl_max;      // Request VLMAX
		logic      reset_vstart;
	} vec_req_t;

	typedef struct packed {
		logic     use_rd;
		reg_idx_t rd;
		elen_t    data;
	} vec_result_t;

endpackage : vec_cfg_pkg

// File: vec_issue_reg.sv
/*
 * Issue stage register. Samples the scalar core's instruction strobe
 * together with the instruction word and both operand values.
 */
module vec_issue_reg import vec_cfg_pkg::*; (
	input  logic   clk_i,
	input  logic   rst_n_i,
	input  logic   instr_valid_i,
	input  instr_t instr_i,
	input  elen_t  rs1_i,
	input  elen_t  rs2_i,
	output logic   valid_o,
	output instr_t instr_o,
	output elen_t  rs1_o,
	output elen_t  rs2_o
);

	logic   valid_q;
	instr_t instr_q;
	elen_t  rs1_q;
	elen_t  rs2_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) valid_q <= 1'b0;
		else          valid_q <= instr_valid_i;
	end

	// Payload only moves with the strobe
	always_ff @(posedge clk_i) begin
		if (instr_valid_i) begin
			instr_q <= instr_i;
			rs1_q   <= rs1_i;
			rs2_q   <= rs2_i;
		end
	end

	assign valid_o = valid_q;
	assign instr_o = instr_q;
	assign rs1_o   = rs1_q;
	assign rs2_o   = rs2_q;

endmodule : vec_issue_reg

// File: vec_cfg_decoder.sv
/*
 * Combinational decoder for the vset instructions and Zicsr accesses to
 * vector CSRs. Produces a request for the CSR file or flags the instruction.
 */
module vec_cfg_decoder import vec_cfg_pkg::*; (
	input  logic     valid_i,
	input  instr_t   instr_i,
	input  elen_t    rs1_i,
	input  elen_t    rs2_i,
	output vec_req_t req_o,
	output logic     valid_o,
	output logic     illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	reg_idx_t   rd_idx;
	reg_idx_t   rs1_idx;
	logic       illegal;
	logic       reg_form;  // AVL taken from rs1
	logic       csr_rw;    // Writable vector CSR
	logic       csr_ro;    // Read-only vector CSR
	vec_req_t   req;

	assign opcode  = instr_i[6:0];
	assign funct3  = instr_i[14:12];
	assign rd_idx  = instr_i[11:7];
	assign rs1_idx = instr_i[19:15];

	always_comb begin : proc_decode
		illegal  = 1'b0;
		reg_form = 1'b0;
		csr_rw   = 1'b0;
		csr_ro   = 1'b0;
		req      = '0;

		case (opcode)
			////////////////////////////////////////////////////////////
			// vset forms
			////////////////////////////////////////////////////////////
			OPCODE_VEC: begin
				req.op           = VCFG;
				req.rd           = rd_idx;
				req.use_rd       = rd_idx != '0;
				req.reset_vstart = 1'b1;

				if (funct3 != FUNCT3_OPCFG) begin
					illegal = 1'b1; // Vector arithmetic not handled here
				end else if (!instr_i[31]) begin // vsetvli
					req.vtype   = {|instr_i[30:28], instr_i[27:20]};
					req.operand = rs1_i;
					reg_form    = 1'b1;
				end else if (instr_i[31:30] == 2'b11) begin // vsetivli
					req.vtype   = {|instr_i[29:28], instr_i[27:20]};
					req.operand = elen_t'(rs1_idx); // uimm is the AVL
				end else if (instr_i[31:25] == 7'b1000000) begin // vsetvl
					req.vtype   = {|rs2_i[31:8], rs2_i[7:0]};
					req.operand = rs1_i;
					reg_form    = 1'b1;
				end else begin
					illegal = 1'b1;
				end

				// x0 special cases exist only for the register forms
				req.avl_max = reg_form && rs1_idx == '0 && rd_idx != '0;
				req.keep_vl = reg_form && rs1_idx == '0 && rd_idx == '0;
			end

			////////////////////////////////////////////////////////////
			// Zicsr on vector CSRs
			////////////////////////////////////////////////////////////
			OPCODE_SYSTEM: begin
				req.op       = VCSR;
				req.rd       = rd_idx;
				req.use_rd   = rd_idx != '0;
				req.csr_addr = instr_i[31:20];
				req.operand  = funct3[2] ? elen_t'(rs1_idx) : rs1_i;

				case (funct3[1:0])
					2'b01: begin
						req.csr_op = CSR_WRITE;
						req.csr_we = 1'b1; // CSRRW always writes
					end
					2'b10: begin
						req.csr_op = CSR_SET;
						req.csr_we = rs1_idx != '0;
					end
					2'b11: begin
						req.csr_op = CSR_CLEAR;
						req.csr_we = rs1_idx != '0;
					end
					default: illegal = 1'b1; // ECALL, EBREAK and friends
				endcase

				case (req.csr_addr)
					CSR_VSTART, CSR_VXSAT, CSR_VXRM, CSR_VCSR: csr_rw = 1'b1;
					CSR_VL, CSR_VTYPE, CSR_VLENB:              csr_ro = 1'b1;
					default:                                   csr_rw = 1'b0;
				endcase

				if (!csr_rw && !(csr_ro && !req.csr_we))
					illegal = 1'b1;
			end

			default: illegal = 1'b1;
		endcase
	end : proc_decode

	assign req_o     = req;
	assign valid_o   = valid_i & ~illegal;
	assign illegal_o = valid_i & illegal;

endmodule : vec_cfg_decoder

// File: vec_csr_file.sv
/*
 * Vector state registers. Computes the new vl for vset requests, applies
 * CSR write, set and clear, and registers the scalar write-back result.
 */
module vec_csr_file import vec_cfg_pkg::*; #(
	parameter int unsigned VLEN = 512
) (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  vec_req_t    req_i,
	input  logic        valid_i,
	input  logic        illegal_i,
	output vec_result_t result_o,
	output logic        result_valid_o,
	output logic        illegal_o,
	output elen_t       vl_o,
	output vtype_t      vtype_o
);

	localparam elen_t VLENB = elen_t'(VLEN / 8);

	// Architectural state
	elen_t  vstart_q;
	elen_t  vl_q;
	vtype_t vtype_q;
	logic   vxsat_q;
	vxrm_t  vxrm_q;

	logic        result_valid_q;
	logic        illegal_q;
	vec_result_t result_q;

	logic   vill;
	elen_t  vlmax;
	elen_t  new_vl;
	vtype_t new_vtype;
	elen_t  csr_rdata;
	elen_t  csr_wdata;

	////////////////////////////////////////////////////////////
	// vset: vill check and vl computation
	////////////////////////////////////////////////////////////

	// Reserved SEW or fractional / reserved LMUL
	assign vill = req_i.vtype[VTYPE_VILL] | req_i.vtype[5] | req_i.vtype[2];

	always_comb begin : proc_vl
		vlmax = elen_t'(VLEN) >> (3 + req_i.vtype[4:3]); // VLEN / SEW
		vlmax = vlmax << req_i.vtype[1:0];               // times LMUL

		if (vill) begin
			new_vtype = VTYPE_RESET;
			new_vl    = '0;
		end else begin
			new_vtype = {1'b0, req_i.vtype[7:0]};
			if (req_i.keep_vl)                new_vl = vl_q;
			else if (req_i.avl_max)           new_vl = vlmax;
			else if (req_i.operand < vlmax)   new_vl = req_i.operand;
			else                              new_vl = vlmax;
		end
	end : proc_vl

	////////////////////////////////////////////////////////////
	// CSR read and modify
	////////////////////////////////////////////////////////////

	always_comb begin : proc_csr
		case (req_i.csr_addr)
			CSR_VSTART: csr_rdata = vstart_q;
			CSR_VXSAT:  csr_rdata = elen_t'(vxsat_q);
			CSR_VXRM:   csr_rdata = elen_t'(vxrm_q);
			CSR_VCSR:   csr_rdata = elen_t'({vxrm_q, vxsat_q});
			CSR_VL:     csr_rdata = vl_q;
			CSR_VTYPE:  csr_rdata = {vtype_q[VTYPE_VILL], 23'b0, vtype_q[7:0]}; // vill in MSB
			CSR_VLENB:  csr_rdata = VLENB;
			default:    csr_rdata = '0;
		endcase

		case (req_i.csr_op)
			CSR_SET:   csr_wdata = csr_rdata | req_i.operand;
			CSR_CLEAR: csr_wdata = csr_rdata & ~req_i.operand;
			default:   csr_wdata = req_i.operand;
		endcase
	end : proc_csr

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			vstart_q <= '0;
			vl_q     <= '0;
			vtype_q  <= VTYPE_RESET;
			vxsat_q  <= 1'b0;
			vxrm_q   <= '0;
		end else if (valid_i) begin
			if (req_i.op == VCFG) begin
				vl_q    <= new_vl;
				vtype_q <= new_vtype;
			end else if (req_i.csr_we) begin
				case (req_i.csr_addr)
					CSR_VSTART: vstart_q           <= csr_wdata;
					CSR_VXSAT:  vxsat_q            <= csr_wdata[0];
					CSR_VXRM:   vxrm_q             <= csr_wdata[1:0];
					CSR_VCSR:   {vxrm_q, vxsat_q}  <= csr_wdata[2:0];
					default:    vxsat_q            <= vxsat_q; // Read-only, never legal here
				endcase
			end
			if (req_i.reset_vstart) vstart_q <= '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Write-back
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			result_valid_q <= 1'b0;
			illegal_q      <= 1'b0;
		end else begin
			result_valid_q <= valid_i;
			illegal_q      <= illegal_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			result_q.use_rd <= req_i.use_rd;
			result_q.rd     <= req_i.rd;
			result_q.data   <= (req_i.op == VCFG) ? new_vl : csr_rdata; // Old CSR value
		end
	end

	assign result_o       = result_q;
	assign result_valid_o = result_valid_q;
	assign illegal_o      = illegal_q;
	assign vl_o           = vl_q;
	assign vtype_o        = vtype_q;

endmodule : vec_csr_file

// File: vec_cfg_unit.sv
/*
 * Top level of the vector configuration unit. Issue register, decoder and
 * CSR file in a fixed two-cycle pipeline. VLEN is chosen here.
 */
module vec_cfg_unit import vec_cfg_pkg::*; #(
	parameter int unsigned VLEN = 512
) (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        instr_valid_i,
	input  instr_t      instr_i,
	input  elen_t       rs1_i,
	input  elen_t       rs2_i,
	output vec_result_t result_o,
	output logic        result_valid_o,
	output logic        illegal_o,
	output elen_t       vl_o,
	output vtype_t      vtype_o
);

	// Issue stage outputs
	logic   issue_valid;
	instr_t issue_instr;
	elen_t  issue_rs1;
	elen_t  issue_rs2;

	// Decoded request
	vec_req_t dec_req;
	logic     dec_valid;
	logic     dec_illegal;

	vec_issue_reg issue_reg_inst (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.rs1_i         (rs1_i),
		.rs2_i         (rs2_i),
		.valid_o       (issue_valid),
		.instr_o       (issue_instr),
		.rs1_o         (issue_rs1),
		.rs2_o         (issue_rs2)
	);

	vec_cfg_decoder decoder_inst (
		.valid_i   (issue_valid),
		.instr_i   (issue_instr),
		.rs1_i     (issue_rs1),
		.rs2_i     (issue_rs2),
		.req_o     (dec_req),
		.valid_o   (dec_valid),
		.illegal_o (dec_illegal)
	);

	vec_csr_file #(
		.VLEN (VLEN)
	) csr_file_inst (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.req_i          (dec_req),
		.valid_i        (dec_valid),
		.illegal_i      (dec_illegal),
		.result_o       (result_o),
		.result_valid_o (result_valid_o),
		.illegal_o      (illegal_o),
		.vl_o           (vl_o),
		.vtype_o        (vtype_o)
	);

endmodule : vec_cfg_unit

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset source. Period of 8, reset held low
 * through the first 10 rising edges.
 */
module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (10) @(posedge clk_o);
		#1 rst_n_o = 1'b1; // Released just after the 10th edge
	end

endmodule : tb_clock_gen

// File: vec_cfg_assertions.sv
/*
 * Concurrent checks on the outputs of the vector configuration unit.
 * Bound into vec_cfg_unit from the testbench top.
 */
module vec_cfg_assertions import vec_cfg_pkg::*; #(
	parameter int unsigned VLEN = 512
) (
	input logic   clk_i,
	input logic   rst_n_i,
	input logic   result_valid_i,
	input logic   illegal_i,
	input elen_t  vl_i,
	input vtype_t vtype_i
);

	// An instruction ends as a result or as illegal, never both
	result_or_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(result_valid_i && illegal_i))
		else $error("result_valid_o and illegal_o high in the same cycle");

	quiet_in_reset: assert property (@(posedge clk_i)
		!rst_n_i |=> (!result_valid_i && !illegal_i))
		else $error("result_valid_o or illegal_o high during reset");

	vill_clears_vl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		vtype_i[VTYPE_VILL] |-> vl_i == '0)
		else $error("vl_o nonzero while vtype_o has vill set");

	// Largest VLMAX is SEW 8 with LMUL 8
	vl_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		vl_i <= elen_t'(VLEN))
		else $error("vl_o above the largest possible VLMAX");

endmodule : vec_cfg_assertions

// File: vec_cfg_checker.sv
/*
 * Reference model and comparator. Watches the unit's inputs at each
 * falling edge, predicts the outputs two cycles later and compares them.
 */
module vec_cfg_checker import vec_cfg_pkg::*; #(
	parameter int unsigned VLEN = 512
) (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        instr_valid_i,
	input  instr_t      instr_i,
	input  elen_t       rs1_i,
	input  elen_t       rs2_i,
	input  vec_result_t result_i,
	input  logic        result_valid_i,
	input  logic        illegal_i,
	input  elen_t       vl_i,
	input  vtype_t      vtype_i,
	input  logic        report_i,
	output int unsigned error_count_o
);

	typedef struct packed {
		logic        valid;
		logic        illegal;
		vec_result_t result;
		elen_t       vl;
		vtype_t      vtype;
	} exp_t;

	exp_t exp_q[$];    // One entry per cycle
	exp_t next_exp;

	// Model state
	elen_t  m_vstart;
	elen_t  m_vl;
	vtype_t m_vtype;
	logic   m_vxsat;
	logic [1:0] m_vxrm;

	int unsigned check_count = 0;
	int unsigned error_count = 0;

	task automatic reset_model();
		m_vstart = '0;
		m_vl     = '0;
		m_vtype  = 9'h100; // vill only
		m_vxsat  = 1'b0;
		m_vxrm   = 2'b00;
	endtask

	////////////////////////////////////////////////////////////
	// Prediction
	////////////////////////////////////////////////////////////

	task automatic predict_instr(input instr_t instr, input elen_t rs1, input elen_t rs2,
			output exp_t e);
		logic [2:0]  funct3;
		reg_idx_t    rd;
		reg_idx_t    rs1_idx;
		logic [31:0] vt_raw;
		logic        reg_form;
		logic        bad;
		logic        read_only;
		logic        do_write;
		int unsigned sew;
		int unsigned lmul;
		elen_t       vlmax;
		elen_t       avl;
		elen_t       src;
		elen_t       old_val;
		elen_t       new_val;
		csr_addr_t   addr;

		funct3    = instr[14:12];
		rd        = instr[11:7];
		rs1_idx   = instr[19:15];
		e         = '0;
		bad       = 1'b0;
		read_only = 1'b0;
		reg_form  = 1'b1;
		vt_raw    = '0;
		old_val   = '0;

		if (instr[6:0] == OPCODE_VEC) begin
			if (funct3 != 3'b111) bad = 1'b1;
			else if (!instr[31]) vt_raw = {21'b0, instr[30:20]};    // vsetvli
			else if (instr[31:30] == 2'b11) begin                    // vsetivli
				vt_raw   = {22'b0, instr[29:20]};
				reg_form = 1'b0;
			end
			else if (instr[31:25] == 7'b1000000) vt_raw = rs2;      // vsetvl
			else bad = 1'b1;

			if (!bad) begin
				if (vt_raw[31:8] != '0 || vt_raw[5:3] > 3 || vt_raw[2:0] > 3) begin
					m_vtype = 9'h100;
					m_vl    = '0;
				end else begin
					sew     = 8 << vt_raw[5:3];
					lmul    = 1 << vt_raw[2:0];
					vlmax   = elen_t'(VLEN / sew * lmul);
					m_vtype = {1'b0, vt_raw[7:0]};
					avl     = reg_form ? rs1 : elen_t'(rs1_idx);
					if (reg_form && rs1_idx == '0) begin
						if (rd != '0) m_vl = vlmax; // rd = x0 keeps vl
					end else begin
						m_vl = (avl < vlmax) ? avl : vlmax;
					end
				end
				m_vstart = '0;
				new_val  = m_vl;
				old_val  = m_vl;
			end
		end else if (instr[6:0] == OPCODE_SYSTEM) begin
			addr     = instr[31:20];
			src      = funct3[2] ? elen_t'(rs1_idx) : rs1;
			do_write = (funct3[1:0] == 2'b01) || (rs1_idx != '0);
			if (funct3[1:0] == 2'b00) bad = 1'b1;
			case (addr)
				CSR_VSTART: old_val = m_vstart;
				CSR_VXSAT:  old_val = {31'b0, m_vxsat};
				CSR_VXRM:   old_val = {30'b0, m_vxrm};
				CSR_VCSR:   old_val = {29'b0, m_vxrm, m_vxsat};
				CSR_VL: begin
					old_val   = m_vl;
					read_only = 1'b1;
				end
				CSR_VTYPE: begin
					old_val   = {m_vtype[8], 23'b0, m_vtype[7:0]};
					read_only = 1'b1;
				end
				CSR_VLENB: begin
					old_val   = elen_t'(VLEN / 8);
					read_only = 1'b1;
				end
				default: bad = 1'b1;
			endcase
			if (read_only && do_write) bad = 1'b1;

			case (funct3[1:0])
				2'b10:   new_val = old_val | src;
				2'b11:   new_val = old_val & ~src;
				default: new_val = src;
			endcase

			if (!bad && do_write) begin
				case (addr)
					CSR_VSTART: m_vstart = new_val;
					CSR_VXSAT:  m_vxsat  = new_val[0];
					CSR_VXRM:   m_vxrm   = new_val[1:0];
					CSR_VCSR: begin
						m_vxrm  = new_val[2:1];
						m_vxsat = new_val[0];
					end
					default: ;
				endcase
			end
		end else begin
			bad = 1'b1; // Unknown opcode
		end

		e.valid         = !bad;
		e.illegal       = bad;
		e.result.use_rd = (rd != '0);
		e.result.rd     = rd;
		e.result.data   = old_val; // New vl for vset
		e.vl            = m_vl;
		e.vtype         = m_vtype;
	endtask

	////////////////////////////////////////////////////////////
	// Comparison
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [37:0] exp_v,
			input logic [37:0] got_v);
		$display("FAILED t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
		error_count++;
	endtask

	task automatic compare_outputs(input exp_t e);
		check_count++;
		if (result_valid_i !== e.valid)
			report_mismatch("result_valid_o", 38'(e.valid), 38'(result_valid_i));
		if (illegal_i !== e.illegal)
			report_mismatch("illegal_o", 38'(e.illegal), 38'(illegal_i));
		if (e.valid && result_i !== e.result)
			report_mismatch("result_o", e.result, result_i);
		if (vl_i !== e.vl)
			report_mismatch("vl_o", 38'(e.vl), 38'(vl_i));
		if (vtype_i !== e.vtype)
			report_mismatch("vtype_o", 38'(e.vtype), 38'(vtype_i));
	endtask

	// Inputs seen here are sampled at the next rising edge
	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			reset_model();
			exp_q.delete();
		end else begin
			if (exp_q.size() == 2) compare_outputs(exp_q.pop_front());
			if (instr_valid_i) begin
				predict_instr(instr_i, rs1_i, rs2_i, next_exp);
			end else begin
				next_exp       = '0;
				next_exp.vl    = m_vl;
				next_exp.vtype = m_vtype;
			end
			exp_q.push_back(next_exp);
		end
	end

	always @(posedge report_i)
		$display("Checker summary: %0d cycles compared, %0d errors", check_count, error_count);

	assign error_count_o = error_count;

endmodule : vec_cfg_checker

// File: vec_cfg_tb.sv
/*
 * Testbench top for the vector configuration unit. Drives a seeded random
 * mix of vset, vector CSR and other instructions; the checker compares.
 */
module vec_cfg_tb import vec_cfg_pkg::*; ();

	localparam int unsigned VLEN           = 512;
	localparam int unsigned NUM_CYCLES     = 2000;
	localparam int unsigned TIMEOUT_CYCLES = NUM_CYCLES + 100; // Reset and drain fit in 100

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	instr_t      instr;
	elen_t       rs1;
	elen_t       rs2;
	vec_result_t result;
	logic        result_valid;
	logic        illegal;
	elen_t       vl;
	vtype_t      vtype;
	logic        report_done;
	int unsigned error_count;
	int unsigned cycle_count = 0;

	tb_clock_gen clock_gen_inst (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	vec_cfg_unit #(
		.VLEN (VLEN)
	) vec_cfg_unit_inst (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.instr_valid_i  (instr_valid),
		.instr_i        (instr),
		.rs1_i          (rs1),
		.rs2_i          (rs2),
		.result_o       (result),
		.result_valid_o (result_valid),
		.illegal_o      (illegal),
		.vl_o           (vl),
		.vtype_o        (vtype)
	);

	vec_cfg_checker #(
		.VLEN (VLEN)
	) checker_inst (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.instr_valid_i  (instr_valid),
		.instr_i        (instr),
		.rs1_i          (rs1),
		.rs2_i          (rs2),
		.result_i       (result),
		.result_valid_i (result_valid),
		.illegal_i      (illegal),
		.vl_i           (vl),
		.vtype_i        (vtype),
		.report_i       (report_done),
		.error_count_o  (error_count)
	);

	bind vec_cfg_unit vec_cfg_assertions #(
		.VLEN (VLEN)
	) assertions_inst (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.result_valid_i (result_valid_o),
		.illegal_i      (illegal_o),
		.vl_i           (vl_o),
		.vtype_i        (vtype_o)
	);

	////////////////////////////////////////////////////////////
	// Random field generators
	////////////////////////////////////////////////////////////

	function automatic reg_idx_t pick_reg();
		reg_idx_t idx;
		idx = reg_idx_t'($urandom);
		if ($urandom % 4 == 0) idx = '0; // x0 special cases
		return idx;
	endfunction

	// Mostly legal vtype, sometimes reserved SEW, fractional LMUL or upper bits
	function automatic logic [31:0] pick_vtype();
		logic [2:0]  sew;
		logic [2:0]  lmul;
		logic [31:0] upper;
		sew   = ($urandom % 8 == 0) ? 3'(4 + $urandom % 4) : 3'($urandom % 4);
		lmul  = ($urandom % 6 == 0) ? 3'(4 + $urandom % 4) : 3'($urandom % 4);
		upper = ($urandom % 10 == 0) ? (32'h100 << ($urandom % 24)) : 32'h0;
		return upper | {24'h0, 2'($urandom), sew, lmul};
	endfunction

	function automatic csr_addr_t pick_csr();
		csr_addr_t addr;
		case ($urandom % 9)
			0:       addr = CSR_VSTART;
			1:       addr = CSR_VXSAT;
			2:       addr = CSR_VXRM;
			3:       addr = CSR_VCSR;
			4:       addr = CSR_VL;
			5:       addr = CSR_VTYPE;
			6:       addr = CSR_VLENB;
			default: addr = csr_addr_t'($urandom);
		endcase
		return addr;
	endfunction

	task automatic drive_random();
		int unsigned kind;
		logic [31:0] vt;
		logic [2:0]  f3;
		reg_idx_t    rd;
		reg_idx_t    rs1f;
		kind = $urandom % 100;
		vt   = pick_vtype();
		rd   = pick_reg();
		rs1f = pick_reg();
		f3   = 3'($urandom);
		if (f3[1:0] == 2'b00 && $urandom % 3 != 0) f3[0] = 1'b1; // Keep most CSR ops legal
		rs1  = ($urandom % 5 == 0) ? elen_t'($urandom) : elen_t'($urandom % 80);
		rs2  = elen_t'($urandom);

		if (kind < 20) instr = {1'b0, vt[10:0], rs1f, FUNCT3_OPCFG, rd, OPCODE_VEC};
		else if (kind < 35) instr = {2'b11, vt[9:0], rs1f, FUNCT3_OPCFG, rd, OPCODE_VEC};
		else if (kind < 45) begin
			instr = {7'b1000000, 5'($urandom), rs1f, FUNCT3_OPCFG, rd, OPCODE_VEC};
			rs2   = vt;
		end
		else if (kind < 85) instr = {pick_csr(), rs1f, f3, rd, OPCODE_SYSTEM};
		else if (kind < 90) instr = {25'($urandom), OPCODE_VEC}; // Arithmetic, bad vset
		else instr = instr_t'($urandom);

		instr_valid = ($urandom % 4 != 0); // Random gaps
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and end of run
	////////////////////////////////////////////////////////////

	initial begin
		instr_valid = 1'b0;
		instr       = '0;
		rs1         = '0;
		rs2         = '0;
		report_done = 1'b0;
		void'($urandom(37));

		// Traffic during reset must leave no trace
		@(posedge clk);
		while (!rst_n) begin
			#1 drive_random();
			@(posedge clk);
		end
		repeat (NUM_CYCLES) begin
			#1 drive_random();
			@(posedge clk);
		end
		#1 instr_valid = 1'b0;
		repeat (4) @(posedge clk); // Two-cycle pipeline drains

		report_done = 1'b1;
		#1;
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, run did not finish", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule : vec_cfg_tb

// File: all.f
vec_cfg_pkg.sv
vec_issue_reg.sv
vec_cfg_decoder.sv
vec_csr_file.sv
vec_cfg_unit.sv
tb_clock_gen.sv
vec_cfg_assertions.sv
vec_cfg_checker.sv
vec_cfg_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the vector configuration unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module vec_cfg_tb -o vec_cfg_sim

out=$(./obj_dir/vec_cfg_sim)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"
